// ==== Makefile ====
VERILATOR = verilator
FLAGS = --binary --timing --assert --timescale 1ns/10ps -Wno-fatal
TOP = tb_branch_profiler
FILELIST = files.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/branch_event_decode.sv ====
`timescale 1ns/10ps

`include "profiler_cfg.svh"

module branch_event_decode (
    input  logic clk,
    input  logic rst,
    input  logic br_valid,
    input  logic br_taken,
    input  logic [`XLEN-1:0] br_pc,
    input  logic [`OFFSET_W-1:0] br_offset,
    input  logic locked,
    output logic ev_valid,
    output logic ev_short_back,
    output logic [`XLEN-1:0] ev_pc
);

    logic signed [`OFFSET_W-1:0] offset_s;
    logic issue_taken;
    logic short_back;

    assign offset_s = br_offset;

    // Taken branch while the table is open
    assign issue_taken = br_valid && br_taken && !locked;

    // Negative and within the short loop window
    assign short_back = (offset_s < 0) && (offset_s > -(`SBB_MAX_OFFSET));

    always_ff @(posedge clk) begin
        if (rst) begin
            ev_valid <= 1'b0;
            ev_short_back <= 1'b0;
        end else begin
            ev_valid <= issue_taken;
            ev_short_back <= issue_taken && short_back;
        end
    end

    // Payload only
    always_ff @(posedge clk) begin
        ev_pc <= br_pc;
    end

    a_short_needs_valid: assert property (
        @(posedge clk) disable iff (rst)
        $rose(ev_short_back) |-> ev_valid
    );

endmodule

// ==== design/branch_profiler.sv ====
`timescale 1ns/10ps

`include "profiler_cfg.svh"

module branch_profiler
    import profiler_pkg::*;
    import core_if_pkg::*;
(
    input  logic clk,
    input  logic rst,

    // Branch unit events
    input  logic br_valid,
    input  logic br_taken,
    input  logic [`XLEN-1:0] br_pc,
    input  logic [`OFFSET_W-1:0] br_offset,

    // Command issue and writeback
    input  logic cmd_valid,
    input  cmd_word_u cmd_word,
    input  logic [`CMD_ID_W-1:0] cmd_id,
    input  logic wb_ack,
    output logic cmd_ready,
    output logic wb_done,
    output logic [`XLEN-1:0] wb_rd,
    output logic [`CMD_ID_W-1:0] wb_id,

    output logic profiler_exception
);

    logic locked;
    logic ev_valid;
    logic ev_short_back;
    logic [`XLEN-1:0] ev_pc;
    logic rd_req;
    logic [`INDEX_W-1:0] rd_index;
    field_id_e rd_field;
    logic [`XLEN-1:0] rd_data;
    logic lock_ack;
    logic lock_state;

    branch_event_decode u_event_decode (
        .clk(clk),
        .rst(rst),
        .br_valid(br_valid),
        .br_taken(br_taken),
        .br_pc(br_pc),
        .br_offset(br_offset),
        .locked(locked),
        .ev_valid(ev_valid),
        .ev_short_back(ev_short_back),
        .ev_pc(ev_pc)
    );

    profiler_cmd_decode u_cmd_decode (
        .clk(clk),
        .rst(rst),
        .cmd_valid(cmd_valid),
        .cmd_ready(cmd_ready),
        .cmd_word(cmd_word),
        .locked(locked),
        .rd_req(rd_req),
        .rd_index(rd_index),
        .rd_field(rd_field),
        .lock_ack(lock_ack),
        .lock_state(lock_state)
    );

    profile_table u_table (
        .clk(clk),
        .rst(rst),
        .ev_valid(ev_valid),
        .ev_short_back(ev_short_back),
        .ev_pc(ev_pc),
        .rd_index(rd_index),
        .rd_field(rd_field),
        .rd_data(rd_data),
        .profiler_exception(profiler_exception)
    );

    profiler_result u_result (
        .clk(clk),
        .rst(rst),
        .cmd_valid(cmd_valid),
        .cmd_id(cmd_id),
        .rd_req(rd_req),
        .rd_data(rd_data),
        .lock_ack(lock_ack),
        .lock_state(lock_state),
        .wb_ack(wb_ack),
        .cmd_ready(cmd_ready),
        .wb_done(wb_done),
        .wb_rd(wb_rd),
        .wb_id(wb_id)
    );

endmodule

// ==== design/core_if_pkg.sv ====
`include "profiler_cfg.svh"

package core_if_pkg;

    // Opcode sits in bit 31 of every command word
    typedef enum logic {
        CMD_READ = 1'b0,
        CMD_TOGGLE_LOCK = 1'b1
    } cmd_op_e;

    // Readback view
    typedef struct packed {
        cmd_op_e op;
        logic [30-`INDEX_W-2:0] reserved;
        logic [`INDEX_W-1:0] entry_index;
        logic [1:0] field_id;
    } read_cmd_t;

    // Lock control view
    typedef struct packed {
        cmd_op_e op;
        logic [29:0] reserved;
        // Toggle is ignored unless set
        logic lock_mask;
    } ctrl_cmd_t;

    // Same 32-bit word, decoded by op
    typedef union packed {
        read_cmd_t rd;
        ctrl_cmd_t ctrl;
    } cmd_word_u;

endpackage

// ==== design/profile_table.sv ====
`timescale 1ns/10ps

`include "profiler_cfg.svh"

module profile_table
    import profiler_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic ev_valid,
    input  logic ev_short_back,
    input  logic [`XLEN-1:0] ev_pc,
    input  logic [`INDEX_W-1:0] rd_index,
    input  field_id_e rd_field,
    output logic [`XLEN-1:0] rd_data,
    output logic profiler_exception
);

    profile_entry_t entries [`NUM_ENTRIES];

    logic [`NUM_ENTRIES-1:0] hit;
    logic [`NUM_ENTRIES-1:0] full;
    logic any_hit;
    logic halve;
    logic [`COUNT_W-1:0] next_count [`NUM_ENTRIES];

    logic alloc;
    logic any_invalid;
    logic [`INDEX_W-1:0] first_invalid;
    logic [`INDEX_W-1:0] lowest_idx;
    logic [`COUNT_W-1:0] lowest_count;
    logic [`INDEX_W-1:0] victim;

    logic [`NUM_ENTRIES-1:0] above_thr;
    logic [`NUM_ENTRIES-1:0] above_thr_r;

    // Fully associative pc match
    always_comb begin
        for (int i = 0; i < `NUM_ENTRIES; i++) begin
            hit[i] = ev_valid && entries[i].valid && (entries[i].pc == ev_pc);
            full[i] = &entries[i].count;
        end
    end

    assign any_hit = |hit;

    // Saturated hit ages the whole table
    assign halve = |(hit & full);

    always_comb begin
        for (int i = 0; i < `NUM_ENTRIES; i++) begin
            next_count[i] = halve ? (entries[i].count >> 1) : entries[i].count;
            if (hit[i]) begin
                next_count[i] = next_count[i] + 1'b1;
            end
        end
    end

    // Lowest invalid slot
    always_comb begin
        first_invalid = '0;
        any_invalid = 1'b0;
        for (int i = `NUM_ENTRIES - 1; i >= 0; i--) begin
            if (!entries[i].valid) begin
                first_invalid = `INDEX_W'(i);
                any_invalid = 1'b1;
            end
        end
    end

    // Least counted slot, strict compare keeps lowest index on ties
    always_comb begin
        lowest_idx = '0;
        lowest_count = entries[0].count;
        for (int i = 1; i < `NUM_ENTRIES; i++) begin
            if (entries[i].count < lowest_count) begin
                lowest_count = entries[i].count;
                lowest_idx = `INDEX_W'(i);
            end
        end
    end

    assign victim = any_invalid ? first_invalid : lowest_idx;

    // Only short backward misses get a slot
    assign alloc = ev_valid && ev_short_back && !any_hit;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_ENTRIES; i++) begin
                entries[i].valid <= 1'b0;
                entries[i].count <= '0;
            end
        end else begin
            for (int i = 0; i < `NUM_ENTRIES; i++) begin
                entries[i].count <= next_count[i];
            end
            if (alloc) begin
                entries[victim].pc <= ev_pc;
                entries[victim].valid <= 1'b1;
                entries[victim].count <= `COUNT_W'(1);
            end
        end
    end

    // Readback of current contents
    always_comb begin
        case (rd_field)
            FIELD_ADDR: rd_data = entries[rd_index].pc;
            FIELD_VALID: rd_data = `XLEN'(entries[rd_index].valid);
            FIELD_COUNT: rd_data = `XLEN'(entries[rd_index].count);
            default: rd_data = '0;
        endcase
    end

    // Hot loop detection
    always_comb begin
        for (int i = 0; i < `NUM_ENTRIES; i++) begin
            above_thr[i] = entries[i].count >= `COUNT_W'(`TAKEN_THRESHOLD);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            above_thr_r <= '0;
            profiler_exception <= 1'b0;
        end else begin
            above_thr_r <= above_thr;
            // No back-to-back pulses
            profiler_exception <= |(above_thr & ~above_thr_r) && !profiler_exception;
        end
    end

    // Allocation only on a miss keeps pcs unique
    a_unique_match: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(hit)
    );

endmodule

// ==== design/profiler_cmd_decode.sv ====
`timescale 1ns/10ps

`include "profiler_cfg.svh"

module profiler_cmd_decode
    import profiler_pkg::*;
    import core_if_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic cmd_valid,
    input  logic cmd_ready,
    input  cmd_word_u cmd_word,
    output logic locked,
    output logic rd_req,
    output logic [`INDEX_W-1:0] rd_index,
    output field_id_e rd_field,
    output logic lock_ack,
    output logic lock_state
);

    logic accept;
    cmd_op_e op;

    assign accept = cmd_valid && cmd_ready;

    // Bit 31 holds the opcode in both views
    assign op = cmd_word.rd.op;

    assign rd_req = accept && (op == CMD_READ);
    assign lock_ack = accept && (op == CMD_TOGGLE_LOCK);

    // Read view
    assign rd_index = cmd_word.rd.entry_index;
    assign rd_field = field_id_e'(cmd_word.rd.field_id);

    // New lock state, returned with the toggle
    assign lock_state = locked ^ cmd_word.ctrl.lock_mask;

    always_ff @(posedge clk) begin
        if (rst) begin
            locked <= 1'b0;
        end else if (lock_ack) begin
            locked <= lock_state;
        end
    end

    a_one_cmd_kind: assert property (
        @(posedge clk) disable iff (rst)
        !(rd_req && lock_ack)
    );

endmodule

// ==== design/profiler_pkg.sv ====
`include "profiler_cfg.svh"

package profiler_pkg;

    // One profile table entry
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic valid;
        logic [`COUNT_W-1:0] count;
    } profile_entry_t;

    // Entry field selected by a readback command
    typedef enum logic [1:0] {
        FIELD_ADDR = 2'd0,
        FIELD_VALID = 2'd1,
        FIELD_COUNT = 2'd2
    } field_id_e;

endpackage

// ==== design/profiler_result.sv ====
`timescale 1ns/10ps

`include "profiler_cfg.svh"

module profiler_result (
    input  logic clk,
    input  logic rst,
    input  logic cmd_valid,
    input  logic [`CMD_ID_W-1:0] cmd_id,
    input  logic rd_req,
    input  logic [`XLEN-1:0] rd_data,
    input  logic lock_ack,
    input  logic lock_state,
    input  logic wb_ack,
    output logic cmd_ready,
    output logic wb_done,
    output logic [`XLEN-1:0] wb_rd,
    output logic [`CMD_ID_W-1:0] wb_id
);

    logic accept;

    assign accept = cmd_valid && cmd_ready;

    // One command in flight
    assign cmd_ready = !wb_done;

    // Set wins over ack
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_done <= 1'b0;
        end else if (accept) begin
            wb_done <= 1'b1;
        end else if (wb_ack) begin
            wb_done <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wb_id <= cmd_id;
        end
        if (rd_req) begin
            wb_rd <= rd_data;
        end else if (lock_ack) begin
            wb_rd <= `XLEN'(lock_state);
        end
    end

    a_hold_result: assert property (
        @(posedge clk) disable iff (rst)
        wb_done && !wb_ack |=> wb_done && $stable(wb_rd) && $stable(wb_id)
    );

endmodule

// ==== files.f ====
+incdir+include
design/profiler_pkg.sv
design/core_if_pkg.sv
design/branch_event_decode.sv
design/profiler_cmd_decode.sv
design/profile_table.sv
design/profiler_result.sv
design/branch_profiler.sv
tests/tb_clock_gen.sv
tests/tb_branch_profiler.sv

// ==== include/profiler_cfg.svh ====
`ifndef PROFILER_CFG_SVH
`define PROFILER_CFG_SVH

// Datapath widths
`define XLEN 32
`define OFFSET_W 20
`define CMD_ID_W 4

// Table geometry, NUM_ENTRIES is 2**INDEX_W
`define NUM_ENTRIES 8
`define INDEX_W 3

// Taken count saturates at 2**COUNT_W - 1
`define COUNT_W 4

// Short backward branch limit in bytes
`define SBB_MAX_OFFSET 256

// Hot loop exception level
`define TAKEN_THRESHOLD 12

`endif

// ==== tests/tb_branch_profiler.sv ====
`timescale 1ns/10ps

`include "profiler_cfg.svh"

module tb_branch_profiler
    import profiler_pkg::*;
    import core_if_pkg::*;
();

    localparam int MAX_ROWS = 128;
    localparam int TIMEOUT = 20;
    localparam int FULL_COUNT = (1 << `COUNT_W) - 1;

    // Row kinds
    localparam int K_BRANCH = 0;
    localparam int K_READ = 1;
    localparam int K_TOGGLE = 2;
    localparam int K_ACK_DELAY = 3;
    localparam int K_PULSES = 4;

    logic clk;
    logic rst;
    logic br_valid;
    logic br_taken;
    logic [`XLEN-1:0] br_pc;
    logic [`OFFSET_W-1:0] br_offset;
    logic cmd_valid;
    cmd_word_u cmd_word;
    logic [`CMD_ID_W-1:0] cmd_id;
    logic wb_ack;
    logic cmd_ready;
    logic wb_done;
    logic [`XLEN-1:0] wb_rd;
    logic [`CMD_ID_W-1:0] wb_id;
    logic profiler_exception;

    // Stimulus table
    // Arg holds the taken flag, index*4+field, the mask or the delay
    int row_kind [MAX_ROWS];
    logic [`XLEN-1:0] row_pc [MAX_ROWS];
    int row_off [MAX_ROWS];
    int row_arg [MAX_ROWS];
    logic [`XLEN-1:0] row_exp [MAX_ROWS];
    string row_name [MAX_ROWS];
    int n_rows = 0;

    // Reference model
    logic [`XLEN-1:0] m_pc [`NUM_ENTRIES];
    bit m_valid [`NUM_ENTRIES];
    int m_count [`NUM_ENTRIES];
    bit m_locked = 1'b0;
    int m_pulses = 0;

    logic [31:0] lfsr_state = 32'd77693;
    int errors = 0;
    int pulse_count = 0;
    int ack_delay = 0;

    tb_clock_gen u_clk_gen (.clk(clk));

    branch_profiler uut (
        .clk(clk),
        .rst(rst),
        .br_valid(br_valid),
        .br_taken(br_taken),
        .br_pc(br_pc),
        .br_offset(br_offset),
        .cmd_valid(cmd_valid),
        .cmd_word(cmd_word),
        .cmd_id(cmd_id),
        .wb_ack(wb_ack),
        .cmd_ready(cmd_ready),
        .wb_done(wb_done),
        .wb_rd(wb_rd),
        .wb_id(wb_id),
        .profiler_exception(profiler_exception)
    );

    always @(negedge clk) begin
        if (!rst && profiler_exception) begin
            pulse_count++;
        end
    end

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic logic [`XLEN-1:0] random_pc();
        logic [29:0] bits;
        bits = '0;
        for (int b = 0; b < 30; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[28:0], lfsr_state[0]};
        end
        return {bits, 2'b00};
    endfunction

    function automatic void model_branch(input logic [`XLEN-1:0] pc, input int off,
                                         input bit taken);
        int hit_idx;
        int victim;
        int old_count [`NUM_ENTRIES];
        bit crossed;
        if (m_locked || !taken) begin
            return;
        end
        hit_idx = -1;
        victim = -1;
        crossed = 1'b0;
        for (int i = 0; i < `NUM_ENTRIES; i++) begin
            old_count[i] = m_count[i];
            if (m_valid[i] && m_pc[i] == pc) begin
                hit_idx = i;
            end
            if (!m_valid[i] && victim < 0) begin
                victim = i;
            end
        end
        if (hit_idx >= 0) begin
            if (m_count[hit_idx] == FULL_COUNT) begin
                for (int i = 0; i < `NUM_ENTRIES; i++) begin
                    m_count[i] = m_count[i] / 2;
                end
            end
            m_count[hit_idx]++;
        end else if (off < 0 && -off < `SBB_MAX_OFFSET) begin
            // Table full so the smallest count goes
            if (victim < 0) begin
                victim = 0;
                for (int i = 1; i < `NUM_ENTRIES; i++) begin
                    if (m_count[i] < m_count[victim]) begin
                        victim = i;
                    end
                end
            end
            m_pc[victim] = pc;
            m_valid[victim] = 1'b1;
            m_count[victim] = 1;
        end
        for (int i = 0; i < `NUM_ENTRIES; i++) begin
            if (old_count[i] < `TAKEN_THRESHOLD && m_count[i] >= `TAKEN_THRESHOLD) begin
                crossed = 1'b1;
            end
        end
        if (crossed) begin
            m_pulses++;
        end
    endfunction

    function automatic void push_row(input int kind, input logic [`XLEN-1:0] pc, input int off,
                                     input int arg, input logic [`XLEN-1:0] exp,
                                     input string name);
        row_kind[n_rows] = kind;
        row_pc[n_rows] = pc;
        row_off[n_rows] = off;
        row_arg[n_rows] = arg;
        row_exp[n_rows] = exp;
        row_name[n_rows] = name;
        n_rows++;
    endfunction

    function automatic void add_branch(input logic [`XLEN-1:0] pc, input int off, input bit taken,
                                       input string name);
        model_branch(pc, off, taken);
        push_row(K_BRANCH, pc, off, int'(taken), '0, name);
    endfunction

    function automatic void add_read(input int idx, input field_id_e field, input string name);
        logic [`XLEN-1:0] exp;
        case (field)
            FIELD_ADDR: exp = m_pc[idx];
            FIELD_VALID: exp = `XLEN'(m_valid[idx]);
            default: exp = `XLEN'(m_count[idx]);
        endcase
        push_row(K_READ, '0, 0, idx * 4 + int'(field), exp, name);
    endfunction

    function automatic void add_toggle(input bit mask, input string name);
        if (mask) begin
            m_locked = !m_locked;
        end
        push_row(K_TOGGLE, '0, 0, int'(mask), `XLEN'(m_locked), name);
    endfunction

    function automatic void build_table();
        logic [`XLEN-1:0] pc_a;
        logic [`XLEN-1:0] pc_b;
        logic [`XLEN-1:0] pc_c;
        logic [`XLEN-1:0] fill_pc [6];
        pc_a = 32'h0000_1000;
        pc_b = 32'h0000_1100;
        for (int i = 0; i < `NUM_ENTRIES; i++) begin
            add_read(i, FIELD_VALID, $sformatf("reset_valid_%0d", i));
        end
        add_branch(pc_a, -16, 1'b1, "alloc_a");
        add_branch(32'h0000_2000, 64, 1'b1, "forward");
        add_branch(32'h0000_3000, -512, 1'b1, "long_back");
        add_branch(32'h0000_3100, -256, 1'b1, "at_limit");
        add_branch(32'h0000_4000, -16, 1'b0, "not_taken");
        add_branch(pc_b, -8, 1'b1, "alloc_b");
        add_read(0, FIELD_ADDR, "a_addr");
        add_read(0, FIELD_COUNT, "a_count");
        add_read(1, FIELD_ADDR, "b_addr");
        add_read(1, FIELD_COUNT, "b_count");
        add_read(2, FIELD_VALID, "e2_empty");
        for (int i = 0; i < 10; i++) begin
            add_branch(pc_a, -16, 1'b1, "count_a");
        end
        add_read(0, FIELD_COUNT, "a_count_11");
        push_row(K_PULSES, '0, 0, 0, m_pulses, "no_exc_below");
        add_branch(pc_a, -16, 1'b1, "a_to_12");
        push_row(K_PULSES, '0, 0, 0, m_pulses, "exc_at_12");
        for (int i = 0; i < 3; i++) begin
            add_branch(pc_a, -16, 1'b1, "a_above");
        end
        add_read(0, FIELD_COUNT, "a_count_15");
        push_row(K_PULSES, '0, 0, 0, m_pulses, "no_exc_above");
        for (int i = 0; i < 4; i++) begin
            add_branch(pc_b, -8, 1'b1, "count_b");
        end
        add_branch(pc_a, -16, 1'b1, "a_saturate");
        add_read(0, FIELD_COUNT, "a_halved");
        add_read(1, FIELD_COUNT, "b_halved");
        for (int i = 0; i < 6; i++) begin
            fill_pc[i] = random_pc();
            add_branch(fill_pc[i], -32, 1'b1, "fill");
        end
        add_read(7, FIELD_VALID, "table_full");
        add_branch(fill_pc[0], -32, 1'b1, "hit_e2");
        add_branch(fill_pc[1], -32, 1'b1, "hit_e3");
        pc_c = random_pc();
        add_branch(pc_c, -40, 1'b1, "replace_c");
        add_read(4, FIELD_ADDR, "c_addr");
        add_read(4, FIELD_COUNT, "c_count");
        add_branch(pc_c, -40, 1'b1, "hit_c");
        add_branch(random_pc(), -48, 1'b1, "replace_d");
        add_read(5, FIELD_ADDR, "d_addr");
        add_read(5, FIELD_COUNT, "d_count");
        add_read(4, FIELD_COUNT, "c_kept");
        add_toggle(1'b1, "lock_on");
        add_branch(pc_a, -16, 1'b1, "locked_a");
        add_branch(random_pc(), -16, 1'b1, "locked_new");
        add_read(0, FIELD_COUNT, "a_frozen");
        // Entry 5 is the victim a leaked new branch would take
        add_read(5, FIELD_ADDR, "e5_unchanged");
        add_toggle(1'b0, "mask_clear");
        add_branch(pc_a, -16, 1'b1, "still_locked");
        add_read(0, FIELD_COUNT, "a_still_frozen");
        add_toggle(1'b1, "lock_off");
        add_branch(pc_a, -16, 1'b1, "a_resume");
        add_read(0, FIELD_COUNT, "a_resumed");
        push_row(K_ACK_DELAY, '0, 0, 4, '0, "ack_delay");
        add_read(0, FIELD_ADDR, "stalled_read");
        add_read(1, FIELD_COUNT, "after_ack");
        push_row(K_PULSES, '0, 0, 0, m_pulses, "exc_total");
    endfunction

    task automatic check_value(input string name, input logic [`XLEN-1:0] exp,
                               input logic [`XLEN-1:0] act);
        if (act !== exp) begin
            $display("mismatch %s: expected 0x%08h, actual 0x%08h", name, exp, act);
            errors++;
        end
    endtask

    // Called and returns 5 ns after a rising edge
    task automatic drive_branch(input logic [`XLEN-1:0] pc, input int off, input bit taken);
        br_valid = 1'b1;
        br_taken = taken;
        br_pc = pc;
        br_offset = off[`OFFSET_W-1:0];
        @(posedge clk);
        #5;
        br_valid = 1'b0;
        br_taken = 1'b0;
        // Table takes the event one edge later
        @(posedge clk);
        #5;
    endtask

    task automatic run_command(input cmd_word_u word, input logic [`CMD_ID_W-1:0] id,
                               input logic [`XLEN-1:0] exp, input string name);
        int waited;
        logic [`XLEN-1:0] held_rd;
        logic [`CMD_ID_W-1:0] held_id;
        cmd_valid = 1'b1;
        cmd_word = word;
        cmd_id = id;
        waited = 0;
        while (!cmd_ready && waited < TIMEOUT) begin
            @(posedge clk);
            #5;
            waited++;
        end
        if (!cmd_ready) begin
            $display("%s: command port never became ready", name);
            errors++;
        end
        @(posedge clk);
        #5;
        cmd_valid = 1'b0;
        waited = 0;
        while (!wb_done && waited < TIMEOUT) begin
            @(posedge clk);
            #5;
            waited++;
        end
        if (!wb_done) begin
            $display("%s: no writeback done after the command", name);
            errors++;
        end
        check_value(name, exp, wb_rd);
        check_value({name, "_id"}, `XLEN'(id), `XLEN'(wb_id));
        held_rd = wb_rd;
        held_id = wb_id;
        // Another command waits while ack is held back
        if (ack_delay > 0) begin
            cmd_valid = 1'b1;
            cmd_word.rd.op = CMD_READ;
            cmd_word.rd.entry_index = `INDEX_W'(`NUM_ENTRIES - 1);
            cmd_id = ~id;
            for (int c = 0; c < ack_delay; c++) begin
                @(posedge clk);
                #5;
                check_value("stall_ready", '0, `XLEN'(cmd_ready));
                check_value("stall_rd", held_rd, wb_rd);
                check_value("stall_id", `XLEN'(held_id), `XLEN'(wb_id));
            end
        end
        wb_ack = 1'b1;
        @(posedge clk);
        #5;
        wb_ack = 1'b0;
        cmd_valid = 1'b0;
        ack_delay = 0;
        check_value({name, "_done_clear"}, '0, `XLEN'(wb_done));
    endtask

    task automatic check_pulses(input logic [`XLEN-1:0] exp, input string name);
        int waited;
        waited = 0;
        while (pulse_count < int'(exp) && waited < TIMEOUT) begin
            @(posedge clk);
            #5;
            waited++;
        end
        check_value(name, exp, `XLEN'(pulse_count));
    endtask

    initial begin
        cmd_word_u word;
        rst = 1'b1;
        br_valid = 1'b0;
        br_taken = 1'b0;
        br_pc = '0;
        br_offset = '0;
        cmd_valid = 1'b0;
        cmd_word = '0;
        cmd_id = '0;
        wb_ack = 1'b0;
        build_table();
        repeat (2) @(posedge clk);
        #5;
        rst = 1'b0;
        for (int r = 0; r < n_rows; r++) begin
            word = '0;
            case (row_kind[r])
                K_BRANCH: drive_branch(row_pc[r], row_off[r], row_arg[r] != 0);
                K_READ: begin
                    word.rd.op = CMD_READ;
                    word.rd.entry_index = `INDEX_W'(row_arg[r] / 4);
                    word.rd.field_id = 2'(row_arg[r] % 4);
                    run_command(word, `CMD_ID_W'(r), row_exp[r], row_name[r]);
                end
                K_TOGGLE: begin
                    word.ctrl.op = CMD_TOGGLE_LOCK;
                    word.ctrl.lock_mask = row_arg[r][0];
                    run_command(word, `CMD_ID_W'(r), row_exp[r], row_name[r]);
                end
                K_ACK_DELAY: ack_delay = row_arg[r];
                default: check_pulses(row_exp[r], row_name[r]);
            endcase
        end
        $display("errors: %0d, exception pulses: %0d", errors, pulse_count);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter real PERIOD_NS = 100.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk = ~clk;
        end
    end

endmodule
